//--- all.f
logic/axi_mem_pkg.sv
logic/axi_burst_accept.sv
logic/burst_addr_gen.sv
logic/banked_sram.sv
logic/axi_mem_responder.sv
logic/axi_mem_top.sv
tb/axi_mem_tb.sv

//--- logic/axi_burst_accept.sv
module axi_burst_accept (
    input  logic                                aclk,
    input  logic                                reset_n,
    input  logic                                arvalid,
    output logic                                arready,
    input  logic [axi_mem_pkg::addr_width-1:0]  araddr,
    input  logic [axi_mem_pkg::id_width-1:0]    arid,
    input  logic [7:0]                          arlen,
    input  logic [2:0]                          arsize,
    input  logic [1:0]                          arburst,
    input  logic                                awvalid,
    output logic                                awready,
    input  logic [axi_mem_pkg::addr_width-1:0]  awaddr,
    input  logic [axi_mem_pkg::id_width-1:0]    awid,
    input  logic [7:0]                          awlen,
    input  logic [2:0]                          awsize,
    input  logic [1:0]                          awburst,
    input  logic                                wvalid,
    output logic                                wready,
    input  logic [axi_mem_pkg::data_width-1:0]  wdata,
    input  logic [axi_mem_pkg::strb_width-1:0]  wstrb,
    input  logic                                wlast,
    input  logic                                done,
    input  logic                                wfifo_pop,
    output logic                                start,
    output logic                                is_write,
    output axi_mem_pkg::burst_cmd_t             cmd,
    output axi_mem_pkg::wr_beat_t               wr_beat,
    output logic                                wfifo_empty
);

    axi_mem_pkg::burst_cmd_t ar_cmd;
    axi_mem_pkg::burst_cmd_t aw_cmd;
    axi_mem_pkg::wr_beat_t   fifo_mem [axi_mem_pkg::wfifo_depth];

    logic ar_seen;
    logic aw_seen;
    logic wlast_seen;
    logic busy;
    logic ar_hs;
    logic aw_hs;
    logic w_hs;
    logic rd_go;
    logic wr_go;

    logic [$clog2(axi_mem_pkg::wfifo_depth)-1:0] wr_ptr;
    logic [$clog2(axi_mem_pkg::wfifo_depth)-1:0] rd_ptr;
    logic [$clog2(axi_mem_pkg::wfifo_depth):0]   fifo_count;
    logic                                        fifo_full;
    logic                                        fifo_move;
    logic                                        out_valid;

    assign ar_hs = arvalid && arready;
    assign aw_hs = awvalid && awready;
    assign w_hs  = wvalid && wready;

    // Each channel closes after its request and reopens on done
    assign arready = !ar_seen;
    assign awready = !aw_seen;
    assign wready  = !wlast_seen && !fifo_full;

    // Read wins a tie
    assign rd_go = !busy && ar_seen;
    assign wr_go = !busy && aw_seen && wlast_seen && !ar_seen;

    always_ff @(posedge aclk) begin
        if (!reset_n) begin
            ar_seen    <= 1'b0;
            aw_seen    <= 1'b0;
            wlast_seen <= 1'b0;
            busy       <= 1'b0;
            start      <= 1'b0;
            is_write   <= 1'b0;
        end else begin
            start <= 1'b0;
            if (ar_hs) begin
                ar_seen <= 1'b1;
            end
            if (aw_hs) begin
                aw_seen <= 1'b1;
            end
            if (w_hs && wlast) begin
                wlast_seen <= 1'b1;
            end
            if (rd_go || wr_go) begin
                start    <= 1'b1;
                busy     <= 1'b1;
                is_write <= wr_go;
            end else if (done) begin
                busy <= 1'b0;
                if (is_write) begin
                    aw_seen    <= 1'b0;
                    wlast_seen <= 1'b0;
                end else begin
                    ar_seen <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (ar_hs) begin
            ar_cmd <= '{addr: araddr, id: arid, len: arlen, size: arsize,
                        burst: axi_mem_pkg::axi_burst_e'(arburst)};
        end
        if (aw_hs) begin
            aw_cmd <= '{addr: awaddr, id: awid, len: awlen, size: awsize,
                        burst: axi_mem_pkg::axi_burst_e'(awburst)};
        end
        if (rd_go) begin
            cmd <= ar_cmd;
        end else if (wr_go) begin
            cmd <= aw_cmd;
        end
    end

    ////////////////////////////////////////////////////////////
    // W FIFO with registered head
    ////////////////////////////////////////////////////////////

    assign fifo_full   = fifo_count == axi_mem_pkg::wfifo_depth;
    assign fifo_move   = (fifo_count != 0) && (!out_valid || wfifo_pop);
    assign wfifo_empty = !out_valid;

    always_ff @(posedge aclk) begin
        if (w_hs) begin
            fifo_mem[wr_ptr] <= '{data: wdata, strb: wstrb, last: wlast};
        end
        if (fifo_move) begin
            wr_beat <= fifo_mem[rd_ptr];
        end
    end

    always_ff @(posedge aclk) begin
        if (!reset_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fifo_count <= '0;
            out_valid  <= 1'b0;
        end else begin
            if (w_hs) begin
                wr_ptr <= wr_ptr + 1;
            end
            if (fifo_move) begin
                rd_ptr    <= rd_ptr + 1;
                out_valid <= 1'b1;
            end else if (wfifo_pop) begin
                out_valid <= 1'b0;
            end
            if (w_hs && !fifo_move) begin
                fifo_count <= fifo_count + 1;
            end else if (fifo_move && !w_hs) begin
                fifo_count <= fifo_count - 1;
            end
        end
    end

    // Bus is 64 bits wide, bursts stop at 16 beats
    a_size_limit: assert property (@(posedge aclk) disable iff (!reset_n)
        !(arvalid && arsize > axi_mem_pkg::max_axsize)
        && !(awvalid && awsize > axi_mem_pkg::max_axsize));

    a_len_limit: assert property (@(posedge aclk) disable iff (!reset_n)
        !(arvalid && arlen >= axi_mem_pkg::max_burst_beats)
        && !(awvalid && awlen >= axi_mem_pkg::max_burst_beats));

endmodule

//--- logic/axi_mem_pkg.sv
package axi_mem_pkg;

    ////////////////////////////////////////////////////////////
    // Sizes
    ////////////////////////////////////////////////////////////

    localparam int addr_width       = 32;
    localparam int data_width       = 64;
    localparam int strb_width       = 8;
    localparam int id_width         = 4;
    localparam int num_banks        = 4;
    localparam int mem_bytes        = 4096;
    localparam int row_offset_width = 3;
    localparam int bank_row_width   = 7;
    localparam int bank_sel_width   = 2;
    localparam int max_burst_beats  = 16;
    localparam int wfifo_depth      = 16;
    localparam int max_axsize       = 3;

    // Byte address inside the 4 KiB array
    localparam int mem_addr_width = bank_sel_width + bank_row_width + row_offset_width;

    ////////////////////////////////////////////////////////////
    // AXI encodings
    ////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        burst_fixed = 2'b00,
        burst_incr  = 2'b01,
        burst_wrap  = 2'b10
    } axi_burst_e;

    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_exokay = 2'b01,
        resp_slverr = 2'b10,
        resp_decerr = 2'b11
    } axi_resp_e;

    ////////////////////////////////////////////////////////////
    // Stage payloads
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [addr_width-1:0] addr;
        logic [id_width-1:0]   id;
        logic [7:0]            len;
        logic [2:0]            size;
        axi_burst_e            burst;
    } burst_cmd_t;

    // Bank in the top two bits
    typedef struct packed {
        logic [bank_sel_width-1:0]   bank;
        logic [bank_row_width-1:0]   row;
        logic [row_offset_width-1:0] offset;
    } mem_addr_fields_t;

    typedef union packed {
        logic [mem_addr_width-1:0] flat;
        mem_addr_fields_t          fields;
    } mem_addr_u;

    typedef struct packed {
        logic                      en;
        logic                      wr;
        logic [strb_width-1:0]     we;
        logic [bank_sel_width-1:0] bank;
        logic [bank_row_width-1:0] row;
        logic [data_width-1:0]     wdata;
    } bank_access_t;

    typedef struct packed {
        logic [id_width-1:0] id;
        logic                last;
    } rd_tag_t;

    typedef struct packed {
        logic [data_width-1:0] data;
        logic [id_width-1:0]   id;
        logic                  last;
    } rd_beat_t;

    typedef struct packed {
        logic [data_width-1:0] data;
        logic [strb_width-1:0] strb;
        logic                  last;
    } wr_beat_t;

endpackage

//--- logic/axi_mem_responder.sv
module axi_mem_responder (
    input  logic                                aclk,
    input  logic                                reset_n,
    input  logic                                rd_valid,
    input  axi_mem_pkg::rd_beat_t               rd_beat,
    output logic                                rd_room,
    output logic                                rvalid,
    input  logic                                rready,
    output logic [axi_mem_pkg::data_width-1:0]  rdata,
    output logic [axi_mem_pkg::id_width-1:0]    rid,
    output logic [1:0]                          rresp,
    output logic                                rlast,
    input  logic                                b_req,
    input  logic [axi_mem_pkg::id_width-1:0]    b_id,
    output logic                                bvalid,
    input  logic                                bready,
    output logic [axi_mem_pkg::id_width-1:0]    bid,
    output logic [1:0]                          bresp
);

    axi_mem_pkg::rd_beat_t beat_buf [2];

    logic       wr_sel;
    logic       rd_sel;
    logic [1:0] count;
    logic [1:0] occ_next;
    logic       r_pop;

    assign r_pop  = rvalid && rready;
    assign rvalid = count != 0;
    assign rdata  = beat_buf[rd_sel].data;
    assign rid    = beat_buf[rd_sel].id;
    assign rlast  = beat_buf[rd_sel].last;
    assign rresp  = axi_mem_pkg::resp_okay;
    assign bresp  = axi_mem_pkg::resp_okay;

    // Occupancy after this edge, the beat leaving the SRAM included
    assign occ_next = count + {1'b0, rd_valid} - {1'b0, r_pop};
    assign rd_room  = occ_next < 2;

    always_ff @(posedge aclk) begin
        if (rd_valid) begin
            beat_buf[wr_sel] <= rd_beat;
        end
        if (b_req) begin
            bid <= b_id;
        end
    end

    always_ff @(posedge aclk) begin
        if (!reset_n) begin
            wr_sel <= 1'b0;
            rd_sel <= 1'b0;
            count  <= '0;
            bvalid <= 1'b0;
        end else begin
            if (rd_valid) begin
                wr_sel <= !wr_sel;
            end
            if (r_pop) begin
                rd_sel <= !rd_sel;
            end
            count <= occ_next;
            if (b_req) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    // Issue must have honoured rd_room
    a_no_overflow: assert property (@(posedge aclk) disable iff (!reset_n)
        rd_valid |-> (count < 2) || r_pop);

endmodule

//--- logic/axi_mem_top.sv
module axi_mem_top (
    input  logic                                aclk,
    input  logic                                reset_n,
    input  logic                                arvalid,
    output logic                                arready,
    input  logic [axi_mem_pkg::addr_width-1:0]  araddr,
    input  logic [axi_mem_pkg::id_width-1:0]    arid,
    input  logic [7:0]                          arlen,
    input  logic [2:0]                          arsize,
    input  logic [1:0]                          arburst,
    input  logic                                awvalid,
    output logic                                awready,
    input  logic [axi_mem_pkg::addr_width-1:0]  awaddr,
    input  logic [axi_mem_pkg::id_width-1:0]    awid,
    input  logic [7:0]                          awlen,
    input  logic [2:0]                          awsize,
    input  logic [1:0]                          awburst,
    input  logic                                wvalid,
    output logic                                wready,
    input  logic [axi_mem_pkg::data_width-1:0]  wdata,
    input  logic [axi_mem_pkg::strb_width-1:0]  wstrb,
    input  logic                                wlast,
    output logic                                rvalid,
    input  logic                                rready,
    output logic [axi_mem_pkg::data_width-1:0]  rdata,
    output logic [axi_mem_pkg::id_width-1:0]    rid,
    output logic [1:0]                          rresp,
    output logic                                rlast,
    output logic                                bvalid,
    input  logic                                bready,
    output logic [axi_mem_pkg::id_width-1:0]    bid,
    output logic [1:0]                          bresp
);

    // Links between the four stages
    logic                              start;
    logic                              is_write;
    axi_mem_pkg::burst_cmd_t           cmd;
    logic                              done;
    logic                              wfifo_pop;
    axi_mem_pkg::wr_beat_t             wr_beat;
    logic                              wfifo_empty;
    axi_mem_pkg::bank_access_t         access;
    axi_mem_pkg::rd_tag_t              rd_tag;
    logic                              rd_valid;
    axi_mem_pkg::rd_beat_t             rd_beat;
    logic                              rd_room;
    logic                              b_req;
    logic [axi_mem_pkg::id_width-1:0]  b_id;

    axi_burst_accept u_accept (.*);

    burst_addr_gen u_addr_gen (.*);

    banked_sram u_sram (.*);

    axi_mem_responder u_responder (.*);

endmodule

//--- logic/banked_sram.sv
module banked_sram (
    input  logic                       aclk,
    input  axi_mem_pkg::bank_access_t  access,
    input  axi_mem_pkg::rd_tag_t       rd_tag,
    output logic                       rd_valid,
    output axi_mem_pkg::rd_beat_t      rd_beat
);

    // One row array per bank
    logic [axi_mem_pkg::data_width-1:0] mem [axi_mem_pkg::num_banks]
        [axi_mem_pkg::mem_bytes / axi_mem_pkg::num_banks / axi_mem_pkg::strb_width];

    always_ff @(posedge aclk) begin
        rd_valid <= access.en && !access.wr;
        if (access.en && access.wr) begin
            for (int lane = 0; lane < axi_mem_pkg::strb_width; lane++) begin
                if (access.we[lane]) begin
                    mem[access.bank][access.row][lane*8 +: 8] <= access.wdata[lane*8 +: 8];
                end
            end
        end
        // Tag rides along with the row
        if (access.en && !access.wr) begin
            rd_beat <= '{data: mem[access.bank][access.row],
                         id: rd_tag.id,
                         last: rd_tag.last};
        end
    end

endmodule

//--- logic/burst_addr_gen.sv
module burst_addr_gen (
    input  logic                              aclk,
    input  logic                              reset_n,
    input  logic                              start,
    input  logic                              is_write,
    input  axi_mem_pkg::burst_cmd_t           cmd,
    input  axi_mem_pkg::wr_beat_t             wr_beat,
    input  logic                              wfifo_empty,
    input  logic                              rd_room,
    output logic                              wfifo_pop,
    output axi_mem_pkg::bank_access_t         access,
    output axi_mem_pkg::rd_tag_t              rd_tag,
    output logic                              done,
    output logic                              b_req,
    output logic [axi_mem_pkg::id_width-1:0]  b_id
);

    logic                                    active;
    logic                                    wr_burst;
    logic                                    issue;
    logic                                    last_beat;
    logic [axi_mem_pkg::id_width-1:0]        burst_id;
    logic [7:0]                              burst_len;
    logic [7:0]                              beat_cnt;
    axi_mem_pkg::axi_burst_e                 burst_kind;
    logic [axi_mem_pkg::mem_addr_width-1:0]  size_bytes;
    logic [axi_mem_pkg::mem_addr_width-1:0]  aligned;
    logic [axi_mem_pkg::mem_addr_width-1:0]  container;
    logic [axi_mem_pkg::mem_addr_width-1:0]  lower_wrap;
    logic [axi_mem_pkg::mem_addr_width-1:0]  start_size;
    logic [axi_mem_pkg::mem_addr_width-1:0]  start_container;
    logic [axi_mem_pkg::mem_addr_width-1:0]  start_aligned;
    axi_mem_pkg::mem_addr_u                  cur;
    axi_mem_pkg::mem_addr_u                  nxt;

    // Burst geometry from the new command
    assign start_size = {{(axi_mem_pkg::mem_addr_width-1){1'b0}}, 1'b1} << cmd.size;
    assign start_container =
        ({{(axi_mem_pkg::mem_addr_width-8){1'b0}}, cmd.len} + 1) << cmd.size;
    assign start_aligned =
        cmd.addr[axi_mem_pkg::mem_addr_width-1:0] & ~(start_size - 1);

    always_comb begin
        unique case (burst_kind)
            axi_mem_pkg::burst_fixed: nxt.flat = aligned;
            axi_mem_pkg::burst_wrap:  nxt.flat = lower_wrap
                                          | ((cur.flat + size_bytes) & (container - 1));
            default:                  nxt.flat = cur.flat + size_bytes;
        endcase
    end

    assign issue     = active && (wr_burst ? !wfifo_empty : rd_room);
    assign last_beat = beat_cnt == burst_len;
    assign wfifo_pop = issue && wr_burst;
    assign rd_tag    = '{id: burst_id, last: last_beat};
    assign b_id      = burst_id;

    always_comb begin
        access.en    = issue;
        access.wr    = wr_burst;
        access.we    = wr_burst ? wr_beat.strb : '0;
        access.bank  = cur.fields.bank;
        access.row   = cur.fields.row;
        access.wdata = wr_beat.data;
    end

    always_ff @(posedge aclk) begin
        if (!reset_n) begin
            active <= 1'b0;
            done   <= 1'b0;
            b_req  <= 1'b0;
        end else begin
            done  <= issue && last_beat;
            b_req <= issue && last_beat && wr_burst;
            if (start) begin
                active <= 1'b1;
            end else if (issue && last_beat) begin
                active <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (start) begin
            wr_burst   <= is_write;
            burst_id   <= cmd.id;
            burst_len  <= cmd.len;
            burst_kind <= cmd.burst;
            size_bytes <= start_size;
            container  <= start_container;
            aligned    <= start_aligned;
            lower_wrap <= cmd.addr[axi_mem_pkg::mem_addr_width-1:0] & ~(start_container - 1);
            cur.flat   <= start_aligned;
            beat_cnt   <= '0;
        end else if (issue) begin
            cur      <= nxt;
            beat_cnt <= beat_cnt + 1;
        end
    end

    // A new command never lands on a beat being issued
    a_en_in_burst: assert property (@(posedge aclk) disable iff (!reset_n)
        access.en |-> active && !start);

endmodule

//--- run.sh
#!/bin/sh
# Build and run the AXI memory testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module axi_mem_tb \
    -f all.f \
    -o axi_mem_sim

./obj_dir/axi_mem_sim

//--- tb/axi_mem_tb.sv
module axi_mem_tb;

    // 77 beats in 13 bursts take a few hundred cycles even with stalls
    localparam int cycle_limit = 4000;

    logic        aclk;
    logic        reset_n;
    logic        arvalid;
    logic        arready;
    logic [31:0] araddr;
    logic [3:0]  arid;
    logic [7:0]  arlen;
    logic [2:0]  arsize;
    logic [1:0]  arburst;
    logic        awvalid;
    logic        awready;
    logic [31:0] awaddr;
    logic [3:0]  awid;
    logic [7:0]  awlen;
    logic [2:0]  awsize;
    logic [1:0]  awburst;
    logic        wvalid;
    logic        wready;
    logic [63:0] wdata;
    logic [7:0]  wstrb;
    logic        wlast;
    logic        rvalid;
    logic        rready;
    logic [63:0] rdata;
    logic [3:0]  rid;
    logic [1:0]  rresp;
    logic        rlast;
    logic        bvalid;
    logic        bready;
    logic [3:0]  bid;
    logic [1:0]  bresp;

    // Byte image of the 4 KiB memory
    logic [7:0]  mem_model [4096];
    logic [63:0] wbuf_data [16];
    logic [7:0]  wbuf_strb [16];
    logic [31:0] seed = 32'hee76;
    int          cycles = 0;

    axi_mem_top uut (.*);

    initial begin
        aclk = 1'b0;
        forever #5 aclk = ~aclk;
    end

    always @(posedge aclk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Result: FAILED");
            $fatal(1, "Timeout: tests still running after %0d cycles", cycle_limit);
        end
    end

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // Beat address from the AXI burst rules for 8-byte beats
    function automatic logic [11:0] beat_addr(input logic [11:0] addr, input logic [7:0] len,
                                              input logic [1:0] burst, input int n);
        logic [11:0] aligned;
        logic [11:0] span;
        logic [11:0] lower;
        aligned = addr & ~12'h007;
        span    = 12'((int'(len) + 1) * 8);
        lower   = addr & ~(span - 12'd1);
        if (burst == 2'b00) begin
            return aligned;
        end else if (burst == 2'b10) begin
            return lower + 12'((int'(aligned - lower) + n * 8) % int'(span));
        end
        return aligned + 12'(n * 8);
    endfunction

    function automatic logic [63:0] model_row(input logic [11:0] addr);
        logic [63:0] row;
        for (int i = 0; i < 8; i++) begin
            row[i*8 +: 8] = mem_model[addr + 12'(i)];
        end
        return row;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("Result: FAILED");
            $fatal(1, "Check on %s failed", name);
        end
    endtask

    task automatic tick();
        @(posedge aclk);
        #1;
    endtask

    // All channels open and no response pending
    task automatic check_idle_state();
        check_value("arready", arready, 1);
        check_value("awready", awready, 1);
        check_value("wready", wready, 1);
        check_value("rvalid", rvalid, 0);
        check_value("bvalid", bvalid, 0);
    endtask

    task automatic fill_write_data(input int beats);
        for (int n = 0; n < beats; n++) begin
            wbuf_data[n] = {lcg_next(), lcg_next()};
            wbuf_strb[n] = 8'hff;
        end
    endtask

    task automatic apply_to_model(input logic [11:0] addr, input logic [7:0] len,
                                  input logic [1:0] burst);
        logic [11:0] a;
        for (int n = 0; n <= int'(len); n++) begin
            a = beat_addr(addr, len, burst, n);
            for (int i = 0; i < 8; i++) begin
                if (wbuf_strb[n][i]) begin
                    mem_model[a + 12'(i)] = wbuf_data[n][i*8 +: 8];
                end
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Channel drivers
    ////////////////////////////////////////////////////////////

    task automatic send_ar(input logic [11:0] addr, input logic [3:0] id,
                           input logic [7:0] len, input logic [1:0] burst);
        arvalid = 1'b1;
        araddr  = {20'h0, addr};
        arid    = id;
        arlen   = len;
        arsize  = 3'd3;
        arburst = burst;
        while (!arready) tick();
        tick();
        arvalid = 1'b0;
        check_value("arready", arready, 0);
    endtask

    task automatic send_aw(input logic [11:0] addr, input logic [3:0] id,
                           input logic [7:0] len, input logic [1:0] burst);
        awvalid = 1'b1;
        awaddr  = {20'h0, addr};
        awid    = id;
        awlen   = len;
        awsize  = 3'd3;
        awburst = burst;
        while (!awready) tick();
        tick();
        awvalid = 1'b0;
        check_value("awready", awready, 0);
    endtask

    task automatic send_w_beats(input logic [7:0] len);
        for (int n = 0; n <= int'(len); n++) begin
            wvalid = 1'b1;
            wdata  = wbuf_data[n];
            wstrb  = wbuf_strb[n];
            wlast  = (n == int'(len));
            while (!wready) tick();
            tick();
        end
        wvalid = 1'b0;
        wlast  = 1'b0;
        check_value("wready", wready, 0);
    endtask

    task automatic wait_bresp(input logic [3:0] id);
        bready = 1'b1;
        while (!bvalid) tick();
        check_value("bid", bid, id);
        check_value("bresp", bresp, axi_mem_pkg::resp_okay);
        tick();
        bready = 1'b0;
        check_value("bvalid", bvalid, 0);
    endtask

    // Takes R beats and predicts each one from the model
    task automatic collect_r(input logic [11:0] addr, input logic [3:0] id,
                             input logic [7:0] len, input logic [1:0] burst, input bit stall);
        int          beat;
        logic [31:0] r;
        beat = 0;
        while (beat <= int'(len)) begin
            r = lcg_next();
            rready = stall ? r[16] : 1'b1;
            if (rvalid && rready) begin
                check_value("rdata", rdata, model_row(beat_addr(addr, len, burst, beat)));
                check_value("rid", rid, id);
                check_value("rresp", rresp, axi_mem_pkg::resp_okay);
                check_value("rlast", rlast, beat == int'(len));
                beat++;
            end
            tick();
        end
        rready = 1'b0;
        check_value("rvalid", rvalid, 0);
    endtask

    task automatic write_burst(input logic [11:0] addr, input logic [3:0] id,
                               input logic [7:0] len, input logic [1:0] burst);
        send_aw(addr, id, len, burst);
        send_w_beats(len);
        wait_bresp(id);
        apply_to_model(addr, len, burst);
    endtask

    task automatic read_burst(input logic [11:0] addr, input logic [3:0] id,
                              input logic [7:0] len, input logic [1:0] burst, input bit stall);
        send_ar(addr, id, len, burst);
        collect_r(addr, id, len, burst, stall);
    endtask

    ////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////

    task automatic incr_round_trip();
        fill_write_data(8);
        write_burst(12'h100, 4'h3, 8'd7, axi_mem_pkg::burst_incr);
        read_burst(12'h100, 4'h5, 8'd7, axi_mem_pkg::burst_incr, 1'b0);
    endtask

    // Rows come back as 0x218, 0x200, 0x208, 0x210
    task automatic wrap_read();
        fill_write_data(4);
        write_burst(12'h200, 4'h1, 8'd3, axi_mem_pkg::burst_incr);
        read_burst(12'h218, 4'h9, 8'd3, axi_mem_pkg::burst_wrap, 1'b0);
    endtask

    task automatic fixed_strobe_write();
        fill_write_data(4);
        // Overlapping lanes that cover all eight
        wbuf_strb[0] = 8'h0f;
        wbuf_strb[1] = 8'h3c;
        wbuf_strb[2] = 8'hf0;
        wbuf_strb[3] = 8'h81;
        write_burst(12'h300, 4'h7, 8'd3, axi_mem_pkg::burst_fixed);
        read_burst(12'h300, 4'h2, 8'd0, axi_mem_pkg::burst_incr, 1'b0);
    endtask

    // Bank 0 into bank 1 at 0x400
    task automatic bank_crossing();
        fill_write_data(5);
        write_burst(12'h3f0, 4'ha, 8'd4, axi_mem_pkg::burst_incr);
        read_burst(12'h3f0, 4'hb, 8'd4, axi_mem_pkg::burst_incr, 1'b0);
    endtask

    task automatic read_backpressure();
        fill_write_data(16);
        write_burst(12'h600, 4'hc, 8'd15, axi_mem_pkg::burst_incr);
        read_burst(12'h600, 4'hd, 8'd15, axi_mem_pkg::burst_incr, 1'b1);
    endtask

    // AR lands before wlast, so the read goes first and sees old data
    task automatic read_write_overlap();
        fill_write_data(2);
        send_aw(12'h100, 4'h4, 8'd1, axi_mem_pkg::burst_incr);
        send_ar(12'h100, 4'h6, 8'd1, axi_mem_pkg::burst_incr);
        send_w_beats(8'd1);
        collect_r(12'h100, 4'h6, 8'd1, axi_mem_pkg::burst_incr, 1'b0);
        wait_bresp(4'h4);
        apply_to_model(12'h100, 8'd1, axi_mem_pkg::burst_incr);
        read_burst(12'h100, 4'h8, 8'd1, axi_mem_pkg::burst_incr, 1'b0);
    endtask

    initial begin
        reset_n = 1'b0;
        arvalid = 1'b0;
        araddr  = '0;
        arid    = '0;
        arlen   = '0;
        arsize  = 3'd3;
        arburst = axi_mem_pkg::burst_incr;
        awvalid = 1'b0;
        awaddr  = '0;
        awid    = '0;
        awlen   = '0;
        awsize  = 3'd3;
        awburst = axi_mem_pkg::burst_incr;
        wvalid  = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wlast   = 1'b0;
        rready  = 1'b0;
        bready  = 1'b0;
        repeat (3) @(posedge aclk);
        #1;
        reset_n = 1'b1;
        tick();
        check_idle_state();

        incr_round_trip();
        wrap_read();
        fixed_strobe_write();
        bank_crossing();
        read_backpressure();
        read_write_overlap();
        check_idle_state();

        $display("Result: PASSED");
        $finish;
    end

endmodule
